/* design/board_bus_pkg.sv */
`default_nettype none

package board_bus_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int ADDR_W = 16;             // Register bus address
    localparam int DATA_W = 32;             // Quadlet data

    // Address spaces, addr[15:12]
    localparam logic [3:0] SPACE_MAIN = 4'h0;
    localparam logic [3:0] SPACE_ETH  = 4'h4;

    // Board registers in channel 0
    localparam logic [3:0] REG_CLKMON = 4'd8;   // Reference clock monitor
    localparam logic [3:0] REG_IPADDR = 4'd11;  // Board IP address
    localparam logic [3:0] REG_ETHRES = 4'd12;  // Ethernet result word

    localparam logic [3:0] ETH_CTRL_BLOCK = 4'hA;   // Port control block, 4xA0

    // ----------------------------------------
    // Address views
    // ----------------------------------------
    typedef struct packed {
        logic [3:0] space;
        logic [3:0] page;                   // Must be 0 for board registers
        logic [3:0] chan;
        logic [3:0] regnum;
    } main_addr_t;

    typedef struct packed {
        logic [3:0] space;
        logic [3:0] port;                   // Ethernet port 1 or 2
        logic [3:0] block;
        logic [3:0] offset;
    } eth_addr_t;

    // Same 16 address bits, decoded per space
    typedef union packed {
        main_addr_t main;
        eth_addr_t  eth;
    } bus_addr_u;

    // Write bus as seen by every register target
    typedef struct packed {
        logic              wen;             // Quadlet write
        logic              blk_wen;         // Block write done
        logic              blk_wstart;      // Block write starting
        bus_addr_u         addr;
        logic [DATA_W-1:0] data;
    } wr_bus_t;

    typedef struct packed {
        logic    req;                       // Master wants the write bus
        wr_bus_t bus;
    } wr_req_t;

    typedef struct packed {
        logic      en;                      // Ethernet owns the read address
        bus_addr_u addr;
    } rd_req_t;

    typedef logic [11:0] port_status_t;     // Per-port status field

endpackage

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
    input  wire logic                   clk_200MHz,
    input  wire logic                   rst_i,
    input  wire board_bus_pkg::wr_req_t bw_req_i,       // Real-time block write engine
    input  wire board_bus_pkg::wr_req_t eth_req_i,      // Ethernet engine
    input  wire board_bus_pkg::wr_req_t fw_req_i,       // FireWire, default owner
    input  wire board_bus_pkg::bus_addr_u fw_raddr_i,
    input  wire board_bus_pkg::rd_req_t eth_rd_i,
    input  wire logic                   sample_busy_i,  // Sampler owns the read address
    input  wire logic [3:0]             sample_chan_i,
    output board_bus_pkg::wr_bus_t      wr_o,
    output board_bus_pkg::bus_addr_u    raddr_o
);
    import board_bus_pkg::*;

    wr_bus_t   wr_sel;
    bus_addr_u raddr_sel;
    logic      burst_open;                  // Block write started, not yet finished

    // ----------------------------------------
    // Write master priority
    // ----------------------------------------
    always_comb begin
        if (bw_req_i.req) begin
            wr_sel      = bw_req_i.bus;
            wr_sel.addr = {{(ADDR_W-8){1'b0}}, bw_req_i.bus.addr[7:0]};  // 8-bit address
        end else if (eth_req_i.req) begin
            wr_sel = eth_req_i.bus;
        end else begin
            wr_sel = fw_req_i.bus;          // FireWire request bit not needed
        end
    end

    // Read address, sampler forces register 0 of its channel
    always_comb begin
        if (sample_busy_i)
            raddr_sel = {SPACE_MAIN, 4'd0, sample_chan_i, 4'd0};
        else if (eth_rd_i.en)
            raddr_sel = eth_rd_i.addr;
        else
            raddr_sel = fw_raddr_i;
    end

    always_ff @(posedge clk_200MHz) begin
        wr_o.addr <= wr_sel.addr;           // Payload
        wr_o.data <= wr_sel.data;
        raddr_o   <= raddr_sel;
        if (rst_i) begin
            wr_o.wen        <= 1'b0;
            wr_o.blk_wen    <= 1'b0;
            wr_o.blk_wstart <= 1'b0;
            burst_open      <= 1'b0;
        end else begin
            wr_o.wen        <= wr_sel.wen;
            wr_o.blk_wen    <= wr_sel.blk_wen;
            wr_o.blk_wstart <= wr_sel.blk_wstart;
            if (wr_o.blk_wstart)
                burst_open <= 1'b1;
            else if (wr_o.blk_wen)
                burst_open <= 1'b0;         // Burst closed
        end
    end

    // Block write end needs a start earlier in the same burst
    a_blk_start_first: assert property (@(posedge clk_200MHz) disable iff (rst_i)
        $rose(wr_o.blk_wen) |-> (wr_o.blk_wstart || burst_open));

endmodule

`default_nettype wire

/* design/read_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module read_decoder (
    input  wire logic                     clk_200MHz,
    input  wire logic                     rst_i,
    input  wire board_bus_pkg::bus_addr_u raddr_i,
    input  wire logic [31:0]              status_rdata_i,   // Channel 0 board registers
    input  wire logic [31:0]              eth1_rdata_i,     // Ethernet port 1
    input  wire logic [31:0]              eth2_rdata_i,     // Ethernet port 2
    input  wire logic [31:0]              ext_rdata_i,      // External board
    output logic [31:0]                   rdata_o
);
    import board_bus_pkg::*;

    logic [DATA_W-1:0] rdata_sel;
    logic              is_chan0;            // MAIN space, page 0, channel 0
    logic              is_status_reg;       // One of the local status registers

    assign is_chan0 = (raddr_i.main.page == 4'd0) && (raddr_i.main.chan == 4'd0);

    assign is_status_reg = (raddr_i.main.regnum == REG_CLKMON) ||
                           (raddr_i.main.regnum == REG_IPADDR) ||
                           (raddr_i.main.regnum == REG_ETHRES);

    // ----------------------------------------
    // Address space decode
    // ----------------------------------------
    always_comb begin
        rdata_sel = ext_rdata_i;            // Default, external board
        case (raddr_i.main.space)
            SPACE_MAIN: begin
                if (is_chan0 && is_status_reg)
                    rdata_sel = status_rdata_i;
            end
            SPACE_ETH: begin
                // Ethernet view, port field selects
                case (raddr_i.eth.port)
                    4'd1:    rdata_sel = eth1_rdata_i;
                    4'd2:    rdata_sel = eth2_rdata_i;
                    default: rdata_sel = '0;    // No such port
                endcase
            end
            default: ;                      // Other spaces live off-chip
        endcase
    end

    // One cycle read latency
    always_ff @(posedge clk_200MHz) begin
        if (rst_i)
            rdata_o <= '0;
        else
            rdata_o <= rdata_sel;
    end

endmodule

`default_nettype wire

/* design/eth_port_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module eth_port_regs #(
    parameter logic [3:0] PORT = 4'd1           // Port number, 1 or 2
) (
    input  wire logic                     clk_200MHz,
    input  wire logic                     rst_i,
    input  wire board_bus_pkg::wr_bus_t   wr_i,
    input  wire board_bus_pkg::bus_addr_u raddr_i,
    output logic [31:0]                   rdata_o,
    output board_bus_pkg::port_status_t   status_o
);
    import board_bus_pkg::*;

    logic [DATA_W-1:0] ctrl_q;              // Port control register
    logic              wr_hit;
    logic              rd_hit;

    // Register at 4xA0, x is the port
    assign wr_hit = wr_i.wen &&
                    (wr_i.addr.eth.space  == SPACE_ETH) &&
                    (wr_i.addr.eth.port   == PORT) &&
                    (wr_i.addr.eth.block  == ETH_CTRL_BLOCK) &&
                    (wr_i.addr.eth.offset == 4'd0);

    assign rd_hit = (raddr_i.eth.space  == SPACE_ETH) &&
                    (raddr_i.eth.port   == PORT) &&
                    (raddr_i.eth.block  == ETH_CTRL_BLOCK) &&
                    (raddr_i.eth.offset == 4'd0);

    always_ff @(posedge clk_200MHz) begin
        if (rst_i)
            ctrl_q <= '0;
        else if (wr_hit)
            ctrl_q <= wr_i.data;
    end

    assign rdata_o  = rd_hit ? ctrl_q : '0;     // Unused offsets read 0
    assign status_o = ctrl_q[11:0];             // Low bits feed the result word

    // No change without a matching write the cycle before
    a_ctrl_write_only: assert property (@(posedge clk_200MHz) disable iff (rst_i)
        !$past(wr_hit) |-> $stable(ctrl_q));

endmodule

`default_nettype wire

/* design/board_status_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module board_status_regs (
    input  wire logic                        clk_200MHz,
    input  wire logic                        rst_i,
    input  wire board_bus_pkg::wr_bus_t      wr_i,
    input  wire board_bus_pkg::bus_addr_u    raddr_i,
    input  wire logic [7:0]                  clk_period_i,    // Measured half-period
    input  wire logic                        clk_ok_i,
    input  wire board_bus_pkg::port_status_t port1_status_i,
    input  wire board_bus_pkg::port_status_t port2_status_i,
    output logic [31:0]                      rdata_o
);
    import board_bus_pkg::*;

    logic [DATA_W-1:0] ip_addr_q;           // Board IP address
    logic [DATA_W-1:0] clk_word;
    logic [DATA_W-1:0] eth_result;
    logic              ip_wen;

    // Full decode, MAIN space channel 0 only
    assign ip_wen = wr_i.wen &&
                    (wr_i.addr.main.space  == SPACE_MAIN) &&
                    (wr_i.addr.main.page   == 4'd0) &&
                    (wr_i.addr.main.chan   == 4'd0) &&
                    (wr_i.addr.main.regnum == REG_IPADDR);

    always_ff @(posedge clk_200MHz) begin
        if (rst_i)
            ip_addr_q <= '0;
        else if (ip_wen)
            ip_addr_q <= wr_i.data;
    end

    // ----------------------------------------
    // Status word layout
    // ----------------------------------------
    assign clk_word = {clk_ok_i, 15'd0, clk_period_i, 8'd0};  // Good flag, period in 15:8

    // Rev 3 marker 01 in 31:30, board status 31:24, then port 2 and port 1
    assign eth_result = {2'b01, 1'b0, clk_ok_i, 4'h0, port2_status_i, port1_status_i};

    // Space and channel already qualified by the read decoder
    always_comb begin
        case (raddr_i.main.regnum)
            REG_CLKMON: rdata_o = clk_word;
            REG_IPADDR: rdata_o = ip_addr_q;
            REG_ETHRES: rdata_o = eth_result;
            default:    rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/clock_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module clock_monitor #(
    parameter int unsigned DIV_BITS = 4,    // Divider width in the monitored domain
    parameter int unsigned OK_LO    = 30,   // Lowest good half-period, system clocks
    parameter int unsigned OK_HI    = 34    // Highest good half-period
) (
    input  wire logic clk_200MHz,
    input  wire logic rst_i,
    input  wire logic mon_clk_i,            // Foreign reference clock
    output logic [7:0] period_o,
    output logic       clk_ok_o
);

    // ----------------------------------------
    // Monitored clock domain
    // ----------------------------------------
    logic [DIV_BITS-1:0] div_cnt = '0;      // Free running, power-up value only

    always_ff @(posedge mon_clk_i) begin
        div_cnt <= div_cnt + 1'b1;
    end

    // ----------------------------------------
    // System domain
    // ----------------------------------------
    logic [1:0] msb_sync;                   // Two-stage synchronizer
    logic       msb_last;                   // Edge detect
    logic [7:0] cyc_cnt;                    // System clocks since last MSB edge

    always_ff @(posedge clk_200MHz) begin
        if (rst_i) begin
            msb_sync <= 2'b00;
            msb_last <= 1'b0;
            cyc_cnt  <= 8'd0;
            period_o <= 8'd0;
        end else begin
            msb_sync <= {msb_sync[0], div_cnt[DIV_BITS-1]};
            msb_last <= msb_sync[1];
            if (msb_sync[1] != msb_last) begin
                period_o <= cyc_cnt;        // Latch half-period
                cyc_cnt  <= 8'd0;
            end else if (cyc_cnt != 8'hFF) begin
                cyc_cnt <= cyc_cnt + 8'd1;
            end else begin
                period_o <= 8'hFF;          // Stopped clock reads bad
            end
        end
    end

    // Closed window
    assign clk_ok_o = (period_o >= OK_LO[7:0]) && (period_o <= OK_HI[7:0]);

endmodule

`default_nettype wire

/* design/board_bus_top.sv */
`timescale 1ns/100ps
`default_nettype none

module board_bus_top #(
    parameter int unsigned DIV_BITS = 4,    // Reference clock divider
    parameter int unsigned OK_LO    = 30,
    parameter int unsigned OK_HI    = 34
) (
    input  wire logic                     clk_200MHz,
    input  wire logic                     rst_i,
    input  wire logic                     mon_clk_i,
    input  wire board_bus_pkg::wr_req_t   bw_req_i,
    input  wire board_bus_pkg::wr_req_t   eth_req_i,
    input  wire board_bus_pkg::wr_req_t   fw_req_i,
    input  wire board_bus_pkg::bus_addr_u fw_raddr_i,
    input  wire board_bus_pkg::rd_req_t   eth_rd_i,
    input  wire logic                     sample_busy_i,
    input  wire logic [3:0]               sample_chan_i,
    input  wire logic [31:0]              ext_rdata_i,
    output board_bus_pkg::wr_bus_t        wr_o,       // Also drives every register file
    output board_bus_pkg::bus_addr_u      raddr_o,
    output logic [31:0]                   rdata_o,
    output logic                          clk_ok_o
);
    import board_bus_pkg::*;

    logic [DATA_W-1:0] status_rdata;
    logic [DATA_W-1:0] eth1_rdata;
    logic [DATA_W-1:0] eth2_rdata;
    port_status_t      port1_status;
    port_status_t      port2_status;
    logic [7:0]        clk_period;

    // ----------------------------------------
    // Bus control
    // ----------------------------------------
    bus_arbiter arb_i (
        .clk_200MHz    (clk_200MHz),
        .rst_i         (rst_i),
        .bw_req_i      (bw_req_i),
        .eth_req_i     (eth_req_i),
        .fw_req_i      (fw_req_i),
        .fw_raddr_i    (fw_raddr_i),
        .eth_rd_i      (eth_rd_i),
        .sample_busy_i (sample_busy_i),
        .sample_chan_i (sample_chan_i),
        .wr_o          (wr_o),
        .raddr_o       (raddr_o)
    );

    read_decoder rdec_i (
        .clk_200MHz     (clk_200MHz),
        .rst_i          (rst_i),
        .raddr_i        (raddr_o),
        .status_rdata_i (status_rdata),
        .eth1_rdata_i   (eth1_rdata),
        .eth2_rdata_i   (eth2_rdata),
        .ext_rdata_i    (ext_rdata_i),
        .rdata_o        (rdata_o)
    );

    // ----------------------------------------
    // Register files
    // ----------------------------------------
    eth_port_regs #(.PORT(4'd1)) eth1_i (
        .clk_200MHz (clk_200MHz),
        .rst_i      (rst_i),
        .wr_i       (wr_o),
        .raddr_i    (raddr_o),
        .rdata_o    (eth1_rdata),
        .status_o   (port1_status)
    );

    eth_port_regs #(.PORT(4'd2)) eth2_i (
        .clk_200MHz (clk_200MHz),
        .rst_i      (rst_i),
        .wr_i       (wr_o),
        .raddr_i    (raddr_o),
        .rdata_o    (eth2_rdata),
        .status_o   (port2_status)
    );

    board_status_regs chan0_i (
        .clk_200MHz     (clk_200MHz),
        .rst_i          (rst_i),
        .wr_i           (wr_o),
        .raddr_i        (raddr_o),
        .clk_period_i   (clk_period),
        .clk_ok_i       (clk_ok_o),
        .port1_status_i (port1_status),
        .port2_status_i (port2_status),
        .rdata_o        (status_rdata)
    );

    clock_monitor #(
        .DIV_BITS (DIV_BITS),
        .OK_LO    (OK_LO),
        .OK_HI    (OK_HI)
    ) clkmon_i (
        .clk_200MHz (clk_200MHz),
        .rst_i      (rst_i),
        .mon_clk_i  (mon_clk_i),
        .period_o   (clk_period),
        .clk_ok_o   (clk_ok_o)
    );

endmodule

`default_nettype wire

/* test/board_bus_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module board_bus_tb;
    import board_bus_pkg::*;

    localparam int SETTLE = 300;            // Monitor settle time and stop time

    // One table row with stimulus and expected results
    typedef struct {
        string       name;
        wr_req_t     bw;
        wr_req_t     eth;
        wr_req_t     fw;
        bus_addr_u   fw_raddr;
        rd_req_t     eth_rd;
        logic        busy;
        logic [3:0]  chan;
        logic [31:0] ext;
        logic        chk_wr;
        wr_bus_t     exp_wr;
        logic        chk_ra;
        bus_addr_u   exp_ra;
        logic        chk_rd;
        logic [31:0] exp_rd;
    } test_t;

    logic        clk_200MHz;
    logic        rst_i;
    logic        mon_clk_i;
    wr_req_t     bw_req;
    wr_req_t     eth_req;
    wr_req_t     fw_req;
    bus_addr_u   fw_raddr;
    rd_req_t     eth_rd;
    logic        sample_busy;
    logic [3:0]  sample_chan;
    logic [31:0] ext_rdata;
    wr_bus_t     wr_o;
    bus_addr_u   raddr_o;
    logic [31:0] rdata_o;
    logic        clk_ok;

    test_t       tests[$];
    logic [31:0] rng_state = 32'h76402714;
    logic        mon_run = 1'b1;            // Cleared to stop the reference clock
    int unsigned cycles = 0;
    int unsigned limit = 0;

    board_bus_top #(
        .DIV_BITS (4),
        .OK_LO    (30),
        .OK_HI    (34)
    ) dut_i (
        .clk_200MHz    (clk_200MHz),
        .rst_i         (rst_i),
        .mon_clk_i     (mon_clk_i),
        .bw_req_i      (bw_req),
        .eth_req_i     (eth_req),
        .fw_req_i      (fw_req),
        .fw_raddr_i    (fw_raddr),
        .eth_rd_i      (eth_rd),
        .sample_busy_i (sample_busy),
        .sample_chan_i (sample_chan),
        .ext_rdata_i   (ext_rdata),
        .wr_o          (wr_o),
        .raddr_o       (raddr_o),
        .rdata_o       (rdata_o),
        .clk_ok_o      (clk_ok)
    );

    // ----------------------------------------
    // Clocks and timeout
    // ----------------------------------------
    initial begin
        clk_200MHz = 1'b0;
        forever #2 clk_200MHz = ~clk_200MHz;
    end

    // 16 ns reference gives a 32-cycle divider MSB half-period
    initial begin
        mon_clk_i = 1'b0;
        forever begin
            #8;
            if (mon_run)
                mon_clk_i = ~mon_clk_i;
        end
    end

    always @(posedge clk_200MHz) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout, run did not finish within %0d cycles", limit);
            $display("sim failed");
            $fatal(1);
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);    // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic wr_bus_t make_bus(input logic [15:0] addr, input logic [31:0] data);
        wr_bus_t b;
        b      = '0;
        b.wen  = 1'b1;                      // Plain quadlet write
        b.addr = addr;
        b.data = data;
        return b;
    endfunction

    function automatic wr_req_t make_req(input logic req, input wr_bus_t bus);
        return {req, bus};
    endfunction

    function automatic test_t blank_test(input string name);
        test_t t;
        t.name     = name;
        t.bw       = '0;
        t.eth      = '0;
        t.fw       = '0;
        t.fw_raddr = '0;
        t.eth_rd   = '0;
        t.busy     = 1'b0;
        t.chan     = 4'd0;
        t.ext      = '0;
        t.chk_wr   = 1'b0;
        t.exp_wr   = '0;
        t.chk_ra   = 1'b0;
        t.exp_ra   = '0;
        t.chk_rd   = 1'b0;
        t.exp_rd   = '0;
        return t;
    endfunction

    task automatic add_write(input string name, input logic use_eth,
                             input logic [15:0] addr, input logic [31:0] data);
        test_t t;
        t = blank_test(name);
        if (use_eth)
            t.eth = make_req(1'b1, make_bus(addr, data));
        else
            t.fw = make_req(1'b0, make_bus(addr, data));   // FireWire needs no request
        t.chk_wr = 1'b1;
        t.exp_wr = make_bus(addr, data);
        tests.push_back(t);
    endtask

    task automatic add_read(input string name, input logic use_eth, input logic [15:0] addr,
                            input logic [31:0] ext, input logic [31:0] exp_rd);
        test_t t;
        t = blank_test(name);
        if (use_eth) begin
            t.eth_rd   = {1'b1, addr};
            t.fw_raddr = ~addr;             // Must lose to Ethernet
        end else begin
            t.fw_raddr = addr;
        end
        t.ext    = ext;
        t.chk_ra = 1'b1;
        t.exp_ra = addr;
        t.chk_rd = 1'b1;
        t.exp_rd = exp_rd;
        tests.push_back(t);
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_wr(input string name, input wr_bus_t exp, input wr_bus_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input bus_addr_u exp, input bus_addr_u act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_data(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_period(input string name, input logic [7:0] lo,
                                input logic [7:0] hi, input logic [7:0] act);
        if ($isunknown(act) || act < lo || act > hi) begin
            $display("FAIL %s: expected %0d..%0d, actual %0d", name, lo, hi, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    task automatic build_table();
        test_t       t;
        logic [31:0] d;
        logic [31:0] d_ip;
        logic [31:0] d_e1;
        logic [31:0] d_e2;
        logic [31:0] r;
        d = next_random();
        t = blank_test("prio_all");
        t.bw  = make_req(1'b1, make_bus(16'h12B7, d));      // Upper byte must vanish
        t.bw.bus.blk_wstart = 1'b1;
        t.eth = make_req(1'b1, make_bus(16'h4F00, ~d));
        t.fw  = make_req(1'b1, make_bus(16'h0F00, d ^ 32'hFFFF));
        t.chk_wr = 1'b1;
        t.exp_wr = make_bus(16'h00B7, d);
        t.exp_wr.blk_wstart = 1'b1;
        t.fw_raddr = 16'h0123;
        t.ext    = next_random();
        t.chk_ra = 1'b1;
        t.exp_ra = 16'h0123;
        t.chk_rd = 1'b1;
        t.exp_rd = t.ext;                   // Page 1 lives off-chip
        tests.push_back(t);
        d = next_random();
        t = blank_test("prio_eth");
        t.bw  = make_req(1'b0, make_bus(16'h00B7, ~d));     // Idle engine whose bus is ignored
        t.eth = make_req(1'b1, make_bus(16'h4F00, d));
        t.fw  = make_req(1'b1, make_bus(16'h0F00, ~d));
        t.chk_wr   = 1'b1;
        t.exp_wr   = make_bus(16'h4F00, d);
        t.eth_rd   = {1'b1, 16'h4350};     // Port 3 does not exist
        t.fw_raddr = 16'h000B;
        t.ext      = next_random();
        t.chk_ra   = 1'b1;
        t.exp_ra   = 16'h4350;
        t.chk_rd   = 1'b1;
        t.exp_rd   = 32'h0;
        tests.push_back(t);
        d = next_random();
        t = blank_test("prio_fw_sample");
        t.fw     = make_req(1'b0, make_bus(16'h0105, d));
        t.chk_wr = 1'b1;
        t.exp_wr = make_bus(16'h0105, d);
        t.busy   = 1'b1;                    // Sampler beats Ethernet
        t.chan   = 4'd5;
        t.eth_rd = {1'b1, 16'h41A0};
        t.ext    = next_random();
        t.chk_ra = 1'b1;
        t.exp_ra = 16'h0050;                // MAIN, page 0, channel 5, register 0
        t.chk_rd = 1'b1;
        t.exp_rd = t.ext;
        tests.push_back(t);
        d_ip = next_random();
        d_e1 = next_random();
        d_e2 = next_random();
        add_write("ip_write", 1'b0, 16'h000B, d_ip);
        add_read("ip_read", 1'b0, 16'h000B, next_random(), d_ip);
        add_write("eth1_write", 1'b1, 16'h41A0, d_e1);
        add_write("eth2_write", 1'b0, 16'h42A0, d_e2);
        add_read("eth1_read", 1'b1, 16'h41A0, next_random(), d_e1);
        add_read("eth2_read", 1'b0, 16'h42A0, next_random(), d_e2);
        add_read("eth1_other_offset", 1'b0, 16'h41A4, next_random(), 32'h0);
        add_read("eth_result", 1'b0, 16'h000C, next_random(),
                 {2'b01, 1'b0, 1'b1, 4'h0, d_e2[11:0], d_e1[11:0]});
        r = next_random();
        add_read("ext_space", 1'b0, 16'h7000, r, r);
        r = next_random();
        add_read("ext_chan", 1'b0, 16'h001B, r, r);
        r = next_random();
        add_read("ext_unused_reg", 1'b0, 16'h0003, r, r);
        r = next_random();
        add_read("ext_page", 1'b0, 16'h0108, r, r);
    endtask

    // Write results one edge after sampling and read data one edge later
    task automatic run_entry(input test_t t);
        @(posedge clk_200MHz);
        bw_req      <= t.bw;
        eth_req     <= t.eth;
        fw_req      <= t.fw;
        fw_raddr    <= t.fw_raddr;
        eth_rd      <= t.eth_rd;
        sample_busy <= t.busy;
        sample_chan <= t.chan;
        ext_rdata   <= t.ext;
        @(posedge clk_200MHz);              // Arbiter samples here
        bw_req  <= '0;                      // Masters drop off while the read source holds
        eth_req <= '0;
        fw_req  <= '0;
        @(negedge clk_200MHz);
        if (t.chk_wr)
            check_wr(t.name, t.exp_wr, wr_o);
        if (t.chk_ra)
            check_addr(t.name, t.exp_ra, raddr_o);
        @(posedge clk_200MHz);              // Read data registered
        @(negedge clk_200MHz);
        if (t.chk_rd)
            check_data(t.name, t.exp_rd, rdata_o);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        test_t t;
        rst_i       <= 1'b1;
        bw_req      <= '0;
        eth_req     <= '0;
        fw_req      <= {1'b0, 3'b111, 16'h0F00, 32'h0};   // Flags high so only reset idles wr_o
        fw_raddr    <= '0;
        eth_rd      <= '0;
        sample_busy <= 1'b0;
        sample_chan <= 4'd0;
        ext_rdata   <= '0;
        build_table();
        limit = tests.size() * 4 + 2 * SETTLE + 400;    // Table plus settle, stop and margin
        repeat (3) @(posedge clk_200MHz);
        rst_i  <= 1'b0;
        fw_req <= '0;
        @(negedge clk_200MHz);
        check_flag("reset_wen", 1'b0, wr_o.wen);
        check_flag("reset_blk_wen", 1'b0, wr_o.blk_wen);
        check_flag("reset_blk_wstart", 1'b0, wr_o.blk_wstart);
        check_flag("reset_clk_ok", 1'b0, clk_ok);
        repeat (SETTLE) @(posedge clk_200MHz);
        @(negedge clk_200MHz);
        check_flag("clk_ok_running", 1'b1, clk_ok);
        foreach (tests[i])
            run_entry(tests[i]);
        t = blank_test("clkmon_read");
        t.fw_raddr = 16'h0008;
        t.chk_ra   = 1'b1;
        t.exp_ra   = 16'h0008;
        run_entry(t);
        check_flag("clkmon_good", 1'b1, rdata_o[31]);
        check_period("clkmon_period", 8'd30, 8'd34, rdata_o[15:8]);
        mon_run = 1'b0;                     // Reference clock stops
        repeat (SETTLE) @(posedge clk_200MHz);
        @(negedge clk_200MHz);
        check_flag("clk_ok_stopped", 1'b0, clk_ok);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
design/board_bus_pkg.sv
design/bus_arbiter.sv
design/read_decoder.sv
design/eth_port_regs.sv
design/board_status_regs.sv
design/clock_monitor.sv
design/board_bus_top.sv
test/board_bus_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = board_bus_tb
FILELIST  = files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
